//--- source/rv_pipe_pkg.sv
package rv_pipe_pkg;

  // Number of bits in an architectural register number from x0 to x31
  localparam int REG_ADDR_W = 5;

  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // Stage in which an instruction's result is produced
  // ALU results exist at the end of EX, the others only later
  typedef enum logic [1:0] {
    RES_ALU = 2'd0,
    RES_LD  = 2'd1,
    RES_CSR = 2'd2,
    RES_M   = 2'd3
  } res_src_e;

  // PC selection driven by the instruction in EX
  typedef enum logic {
    PC_SEL_SEQ      = 1'b0,
    PC_SEL_REDIRECT = 1'b1
  } pc_sel_e;

  // Data memory timing
  // SRAM returns load data inside MEM, BRAM hands it over one stage later in WB
  typedef enum logic {
    MEM_TYPE_SRAM = 1'b0,
    MEM_TYPE_BRAM = 1'b1
  } mem_type_e;

  // Where an ID operand is taken from
  typedef enum logic [1:0] {
    FWD_NONE = 2'd0,
    FWD_MEM  = 2'd1,
    FWD_WB   = 2'd2
  } fwd_sel_e;

  // Instruction descriptor carried through the stage registers
  // Only control information travels here, no operand data
  typedef struct packed {
    logic       valid;
    logic [7:0] tag;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  rd;
    logic       rs1_used;
    logic       rs2_used;
    logic       reg_write;
    logic       is_ld;
    logic       is_csr;
    logic       is_m;
    res_src_e   res_src;
    // Taken jump or branch, resolved in EX
    logic       redir;
    // Branch misprediction, resolved in MEM
    logic       mispred;
  } instr_desc_t;

endpackage

//--- source/rv_stage_reg.sv
`timescale 1ns/1ns

// One pipeline stage register for instruction descriptors
// Priority is reset, then flush, then hold, then load
module rv_stage_reg (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     hold,
  input  logic                     bubble_in,
  input  logic                     flush,
  input  rv_pipe_pkg::instr_desc_t d,
  output rv_pipe_pkg::instr_desc_t q
);

  import rv_pipe_pkg::*;

  logic        valid_q;
  instr_desc_t payload_q;

  // Only the valid bit is control state
  // A flush turns the slot into a bubble even when the stage is held
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else if (flush) begin
      valid_q <= 1'b0;
    end else if (!hold) begin
      // A bubble request drops the incoming instruction at this edge
      valid_q <= d.valid && !bubble_in;
    end
  end

  // The payload follows the input whenever the stage advances
  always_ff @(posedge clk) begin
    if (!hold) begin
      payload_q <= d;
    end
  end

  always_comb begin
    q       = payload_q;
    q.valid = valid_q;
  end

endmodule

//--- source/rv_id_stage.sv
`timescale 1ns/1ns

// IF/ID register
// It captures the descriptor offered by the instruction source and keeps it
// for as long as a data hazard or a memory wait blocks issue
// The source holds its offer for the same cycles, driven by the stall output
module rv_id_stage (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     mem_wait,
  input  logic                     data_hazard_id,
  input  logic                     if_id_flush,
  input  rv_pipe_pkg::instr_desc_t in_instr,
  output rv_pipe_pkg::instr_desc_t id_instr
);

  logic id_hold;

  // ID keeps its instruction both on a data stall and while frozen
  // The bubble for a data stall is inserted one stage later, at ID/EX
  assign id_hold = data_hazard_id || mem_wait;

  // A redirect or mispredict makes the fetched instruction wrong-path,
  // and the flush wins over the hold
  rv_stage_reg if_id_reg_i (
    .clk       (clk),
    .reset     (reset),
    .hold      (id_hold),
    .bubble_in (1'b0),
    .flush     (if_id_flush),
    .d         (in_instr),
    .q         (id_instr)
  );

endmodule

//--- source/rv_hazard_ctrl.sv
`timescale 1ns/1ns

// Central hazard control for the ID, EX, MEM, WB pipeline
// Read-after-write hazards between the ID sources and the destinations of
// EX, MEM and WB are detected here and turned into a stall of ID
// Control flow changes from EX (taken redirect) and MEM (mispredict) are
// turned into flush strobes for IF/ID, ID/EX and EX/MEM
module rv_hazard_ctrl #(
  parameter int                     FWD         = 1,
  parameter int                     FWD_REGFILE = 0,
  parameter rv_pipe_pkg::mem_type_e MEM_TYPE    = rv_pipe_pkg::MEM_TYPE_SRAM
) (
  input  rv_pipe_pkg::instr_desc_t id_instr,
  input  rv_pipe_pkg::instr_desc_t ex_instr,
  input  rv_pipe_pkg::instr_desc_t mem_instr,
  input  rv_pipe_pkg::instr_desc_t wb_instr,
  input  logic                     mem_wait,
  output logic                     data_hazard_id,
  output logic                     if_id_flush,
  output logic                     id_ex_flush,
  output logic                     ex_mem_flush
);

  import rv_pipe_pkg::*;

  // True when the producer will write the register that the consumer reads
  // Writes to x0 are discarded, so they never create a dependency
  function automatic logic dest_hit(input instr_desc_t prod, input reg_addr_t rs,
                                    input logic used);
    return used && prod.valid && prod.reg_write && (prod.rd != '0) && (prod.rd == rs);
  endfunction

  logic ex_hazard_rs1;
  logic ex_hazard_rs2;
  logic ex_hazard;
  logic mem_hazard_rs1;
  logic mem_hazard_rs2;
  logic mem_hazard;
  logic wb_hazard;

  // Dependencies of the ID sources on the instruction in EX
  assign ex_hazard_rs1 = dest_hit(ex_instr, id_instr.rs1, id_instr.rs1_used);
  assign ex_hazard_rs2 = dest_hit(ex_instr, id_instr.rs2, id_instr.rs2_used);
  assign ex_hazard     = ex_hazard_rs1 || ex_hazard_rs2;

  // Dependencies on the instruction in MEM
  assign mem_hazard_rs1 = dest_hit(mem_instr, id_instr.rs1, id_instr.rs1_used);
  assign mem_hazard_rs2 = dest_hit(mem_instr, id_instr.rs2, id_instr.rs2_used);
  assign mem_hazard     = mem_hazard_rs1 || mem_hazard_rs2;

  // A register file with internal write-through hands the WB result to ID
  // in the same cycle, so WB never blocks in that case
  if (FWD_REGFILE != 0) begin : g_wb_regfile_fwd
    assign wb_hazard = 1'b0;
  end else begin : g_wb_hazard
    logic wb_hazard_rs1;
    logic wb_hazard_rs2;

    assign wb_hazard_rs1 = dest_hit(wb_instr, id_instr.rs1, id_instr.rs1_used);
    assign wb_hazard_rs2 = dest_hit(wb_instr, id_instr.rs2, id_instr.rs2_used);
    assign wb_hazard     = wb_hazard_rs1 || wb_hazard_rs2;
  end

  // Control flow changes
  // A taken redirect is acted on while its instruction sits in EX
  pc_sel_e pc_sel;
  logic    pc_redir;
  logic    redir_valid_mem;
  logic    control_flush;

  assign pc_sel = (ex_instr.valid && ex_instr.redir) ? PC_SEL_REDIRECT : PC_SEL_SEQ;
  assign pc_redir = (pc_sel == PC_SEL_REDIRECT);

  // A mispredict is only known once the branch has reached MEM
  assign redir_valid_mem = mem_instr.valid && mem_instr.mispred;

  // Either event squashes the younger instruction in ID, so a stall caused
  // by it would only block the redirect
  assign control_flush = pc_redir || redir_valid_mem;

  if (FWD != 0) begin : g_fwd
    // With forwarding only the results that are not yet available stall
    logic late_ex;
    logic late_mem;

    // Loads, CSR reads and M results never exist by the end of EX
    assign late_ex = ex_instr.is_ld || ex_instr.is_csr || ex_instr.is_m;

    if (MEM_TYPE == MEM_TYPE_BRAM) begin : g_bram
      // BRAM load data only shows up in WB, so a load in MEM must wait too
      assign late_mem = mem_instr.is_ld || mem_instr.is_csr || mem_instr.is_m;
    end else begin : g_sram
      // SRAM load data is ready in MEM and goes through the MEM path
      assign late_mem = mem_instr.is_csr || mem_instr.is_m;
    end

    assign data_hazard_id = ((late_ex && ex_hazard) || (late_mem && mem_hazard) ||
                             wb_hazard) && !control_flush;
  end else begin : g_no_fwd
    // Without forwarding every pending write to a source register stalls
    assign data_hazard_id = (ex_hazard || mem_hazard || wb_hazard) && !control_flush;
  end

  // The instruction in IF/ID is on the wrong path for both kinds of change
  assign if_id_flush = pc_redir || redir_valid_mem;

  // The EX redirect keeps ID/EX while frozen, since the redirecting
  // instruction itself is still there and cannot move to MEM yet
  // A mispredict in MEM always makes the instruction in ID/EX wrong-path
  assign id_ex_flush = (pc_redir && !mem_wait) || redir_valid_mem;

  // While frozen the older instruction in MEM cannot leave for WB,
  // so EX/MEM is cleared only on a cycle that advances
  assign ex_mem_flush = redir_valid_mem && !mem_wait;

endmodule

//--- source/rv_fwd_id.sv
`timescale 1ns/1ns

// Forwarding source selection for the two ID operands
// MEM is preferred over WB because it holds the younger write
module rv_fwd_id #(
  parameter rv_pipe_pkg::mem_type_e MEM_TYPE = rv_pipe_pkg::MEM_TYPE_SRAM
) (
  input  rv_pipe_pkg::instr_desc_t id_instr,
  input  rv_pipe_pkg::instr_desc_t mem_instr,
  input  rv_pipe_pkg::instr_desc_t wb_instr,
  output rv_pipe_pkg::fwd_sel_e    fwd_rs1,
  output rv_pipe_pkg::fwd_sel_e    fwd_rs2
);

  import rv_pipe_pkg::*;

  // True when the producer writes the given nonzero source register
  function automatic logic writes_src(input instr_desc_t prod, input reg_addr_t rs,
                                      input logic used);
    return used && (rs != '0) && prod.valid && prod.reg_write && (prod.rd == rs);
  endfunction

  // Picks the operand source for one register
  function automatic fwd_sel_e pick_src(input logic mem_hit, input logic wb_hit);
    fwd_sel_e sel;
    if (mem_hit) begin
      sel = FWD_MEM;
    end else if (wb_hit) begin
      sel = FWD_WB;
    end else begin
      sel = FWD_NONE;
    end
    return sel;
  endfunction

  logic mem_ready;

  // ALU results are always ready in MEM
  if (MEM_TYPE == MEM_TYPE_SRAM) begin : g_sram
    // SRAM load data arrives inside MEM, so it can be forwarded from there
    assign mem_ready = (mem_instr.res_src == RES_ALU) || (mem_instr.res_src == RES_LD);
  end else begin : g_bram
    assign mem_ready = (mem_instr.res_src == RES_ALU);
  end

  always_comb begin
    fwd_rs1 = pick_src(mem_ready && writes_src(mem_instr, id_instr.rs1, id_instr.rs1_used),
                       writes_src(wb_instr, id_instr.rs1, id_instr.rs1_used));
    fwd_rs2 = pick_src(mem_ready && writes_src(mem_instr, id_instr.rs2, id_instr.rs2_used),
                       writes_src(wb_instr, id_instr.rs2, id_instr.rs2_used));
  end

endmodule

//--- source/rv_pipe_top.sv
`timescale 1ns/1ns

// Top level of the pipeline control subsystem
// Descriptors move ID -> EX -> MEM -> WB under the control of the hazard unit
module rv_pipe_top #(
  parameter int                     FWD         = 1,
  parameter int                     FWD_REGFILE = 0,
  parameter rv_pipe_pkg::mem_type_e MEM_TYPE    = rv_pipe_pkg::MEM_TYPE_BRAM
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     mem_wait,
  input  rv_pipe_pkg::instr_desc_t in_instr,
  output logic                     stall,
  output logic                     redirect,
  output rv_pipe_pkg::instr_desc_t wb_instr,
  output rv_pipe_pkg::fwd_sel_e    fwd_rs1,
  output rv_pipe_pkg::fwd_sel_e    fwd_rs2
);

  import rv_pipe_pkg::*;

  instr_desc_t id_instr;
  instr_desc_t ex_instr;
  instr_desc_t mem_instr;

  logic data_hazard_id;
  logic if_id_flush;
  logic id_ex_flush;
  logic ex_mem_flush;

  // IF/ID register that holds under a data stall or a memory wait
  rv_id_stage id_stage_i (
    .clk            (clk),
    .reset          (reset),
    .mem_wait       (mem_wait),
    .data_hazard_id (data_hazard_id),
    .if_id_flush    (if_id_flush),
    .in_instr       (in_instr),
    .id_instr       (id_instr)
  );

  // ID/EX gets a bubble while ID waits on a data hazard
  rv_stage_reg id_ex_reg_i (
    .clk       (clk),
    .reset     (reset),
    .hold      (mem_wait),
    .bubble_in (data_hazard_id),
    .flush     (id_ex_flush),
    .d         (id_instr),
    .q         (ex_instr)
  );

  rv_stage_reg ex_mem_reg_i (
    .clk       (clk),
    .reset     (reset),
    .hold      (mem_wait),
    .bubble_in (1'b0),
    .flush     (ex_mem_flush),
    .d         (ex_instr),
    .q         (mem_instr)
  );

  // The upstream stages stay frozen during a memory wait while WB drains
  // to a bubble, so the instruction in MEM retires exactly once afterwards
  rv_stage_reg mem_wb_reg_i (
    .clk       (clk),
    .reset     (reset),
    .hold      (1'b0),
    .bubble_in (mem_wait),
    .flush     (1'b0),
    .d         (mem_instr),
    .q         (wb_instr)
  );

  rv_hazard_ctrl #(
    .FWD         (FWD),
    .FWD_REGFILE (FWD_REGFILE),
    .MEM_TYPE    (MEM_TYPE)
  ) hazard_ctrl_i (
    .id_instr       (id_instr),
    .ex_instr       (ex_instr),
    .mem_instr      (mem_instr),
    .wb_instr       (wb_instr),
    .mem_wait       (mem_wait),
    .data_hazard_id (data_hazard_id),
    .if_id_flush    (if_id_flush),
    .id_ex_flush    (id_ex_flush),
    .ex_mem_flush   (ex_mem_flush)
  );

  rv_fwd_id #(
    .MEM_TYPE (MEM_TYPE)
  ) fwd_id_i (
    .id_instr  (id_instr),
    .mem_instr (mem_instr),
    .wb_instr  (wb_instr),
    .fwd_rs1   (fwd_rs1),
    .fwd_rs2   (fwd_rs2)
  );

  // The source must keep offering the same instruction while ID is stalled
  assign stall = data_hazard_id;

  // Every IF/ID flush is a change of fetch direction
  assign redirect = if_id_flush;

endmodule

//--- test/rv_pipe_tb.sv
`timescale 1ns/1ns

module rv_pipe_tb;

  import rv_pipe_pkg::*;

  localparam int          RESET_CYCLES   = 8;
  localparam int          STIM_CYCLES    = 2000;
  // Reset and the final drain add only a few cycles to the stimulus
  localparam int          TIMEOUT_CYCLES = STIM_CYCLES + STIM_CYCLES / 2;
  localparam logic [31:0] SEED           = 32'h9770;

  // The reference model keeps one slot per pipeline stage
  localparam int S_ID  = 0;
  localparam int S_EX  = 1;
  localparam int S_MEM = 2;
  localparam int S_WB  = 3;

  logic        clk;
  logic        reset;
  logic        mem_wait;
  instr_desc_t in_instr;
  logic        stall;
  logic        redirect;
  instr_desc_t wb_instr;
  fwd_sel_e    fwd_rs1;
  fwd_sel_e    fwd_rs2;

  instr_desc_t model_slot [4];
  logic [31:0] rng;
  logic [7:0]  next_tag;
  logic [7:0]  last_tag;
  logic        consumed;
  logic        wait_at_edge;
  logic        draining;
  int          cyc;
  int          present_cyc [256];
  int          timeout_count;
  int          checks;
  int          errors;
  int          retired;

  rv_pipe_top #(
    .FWD         (1),
    .FWD_REGFILE (0),
    .MEM_TYPE    (MEM_TYPE_BRAM)
  ) rv_pipe_top_i (
    .clk      (clk),
    .reset    (reset),
    .mem_wait (mem_wait),
    .in_instr (in_instr),
    .stall    (stall),
    .redirect (redirect),
    .wb_instr (wb_instr),
    .fwd_rs1  (fwd_rs1),
    .fwd_rs2  (fwd_rs2)
  );

  always #5 clk = ~clk;

  // Ends a run that never reaches its summary
  always @(posedge clk) begin
    timeout_count = timeout_count + 1;
    if (timeout_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Checks %0d, errors %0d, retired %0d", checks, errors, retired);
      $display("Regression failed");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // A producer feeds a source when it is valid, writes, and targets that nonzero register
  function automatic logic src_hit(input instr_desc_t prod, input reg_addr_t rs,
                                   input logic used);
    return used && prod.valid && prod.reg_write && (rs != '0) && (prod.rd == rs);
  endfunction

  function automatic logic slot_hazard(input instr_desc_t prod, input instr_desc_t cons);
    return src_hit(prod, cons.rs1, cons.rs1_used) || src_hit(prod, cons.rs2, cons.rs2_used);
  endfunction

  // Loads, CSR reads and M results cannot be forwarded from EX,
  // and with BRAM not from MEM either
  function automatic logic late_result(input instr_desc_t prod);
    return prod.is_ld || prod.is_csr || prod.is_m;
  endfunction

  function automatic logic control_change(input instr_desc_t ex, input instr_desc_t mem);
    return (ex.valid && ex.redir) || (mem.valid && mem.mispred);
  endfunction

  function automatic logic expect_stall(input instr_desc_t id, input instr_desc_t ex,
                                        input instr_desc_t mem, input instr_desc_t wb);
    logic blocked;
    blocked = (late_result(ex) && slot_hazard(ex, id)) ||
              (late_result(mem) && slot_hazard(mem, id)) ||
              slot_hazard(wb, id);
    return blocked && !control_change(ex, mem);
  endfunction

  // Only ALU results are ready in MEM when the data memory is a BRAM
  function automatic fwd_sel_e expect_fwd(input reg_addr_t rs, input logic used,
                                          input instr_desc_t mem, input instr_desc_t wb);
    fwd_sel_e sel;
    sel = FWD_NONE;
    if (src_hit(mem, rs, used) && (mem.res_src == RES_ALU)) begin
      sel = FWD_MEM;
    end else if (src_hit(wb, rs, used)) begin
      sel = FWD_WB;
    end
    return sel;
  endfunction

  // Next content of one slot
  // A bubble slot keeps its old fields, only its valid bit says it is empty
  function automatic instr_desc_t next_slot(input instr_desc_t cur, input instr_desc_t d,
                                            input logic hold, input logic bubble,
                                            input logic flush);
    instr_desc_t nxt;
    nxt = hold ? cur : d;
    if (flush) begin
      nxt.valid = 1'b0;
    end else if (!hold) begin
      nxt.valid = d.valid && !bubble;
    end
    return nxt;
  endfunction

  // Small register numbers make hazards frequent
  task automatic make_instr(output instr_desc_t ins);
    logic [31:0] r;
    rng = xorshift32(rng);
    r = rng;
    ins = '0;
    ins.valid     = (r[24:21] != 4'd0);
    ins.tag       = next_tag;
    ins.rs1       = {3'b000, r[1:0]};
    ins.rs2       = {3'b000, r[3:2]};
    ins.rd        = {3'b000, r[5:4]};
    ins.rs1_used  = r[6];
    ins.rs2_used  = r[7];
    ins.reg_write = (r[10:8] != 3'd0);
    ins.res_src   = res_src_e'(r[12:11]);
    ins.is_ld     = (ins.res_src == RES_LD);
    ins.is_csr    = (ins.res_src == RES_CSR);
    ins.is_m      = (ins.res_src == RES_M);
    // Redirects and mispredicts are rare
    ins.redir     = (r[16:13] == 4'd0);
    ins.mispred   = (r[20:17] == 4'd0);
  endtask

  // Called on the falling edge
  // A new offer is made only when the last edge took the previous one
  task automatic drive_inputs();
    instr_desc_t ins;
    if (consumed) begin
      if (draining) begin
        in_instr = '0;
      end else begin
        make_instr(ins);
        present_cyc[next_tag] = cyc;
        next_tag = next_tag + 8'd1;
        in_instr = ins;
      end
    end
    rng = xorshift32(rng);
    mem_wait = !draining && (rng[2:0] == 3'd0);
  endtask

  // Moves the model by one rising edge using the values seen just before it
  task automatic advance_model();
    logic        st;
    logic        pc_redir;
    logic        misp_mem;
    instr_desc_t nxt_id;
    instr_desc_t nxt_ex;
    instr_desc_t nxt_mem;
    instr_desc_t nxt_wb;
    st = expect_stall(model_slot[S_ID], model_slot[S_EX], model_slot[S_MEM],
                      model_slot[S_WB]);
    pc_redir = model_slot[S_EX].valid && model_slot[S_EX].redir;
    misp_mem = model_slot[S_MEM].valid && model_slot[S_MEM].mispred;
    // WB drains to a bubble while the rest of the pipe is frozen
    nxt_wb  = next_slot(model_slot[S_WB], model_slot[S_MEM], 1'b0, mem_wait, 1'b0);
    nxt_mem = next_slot(model_slot[S_MEM], model_slot[S_EX], mem_wait, 1'b0,
                        misp_mem && !mem_wait);
    nxt_ex  = next_slot(model_slot[S_EX], model_slot[S_ID], mem_wait, st,
                        (pc_redir && !mem_wait) || misp_mem);
    nxt_id  = next_slot(model_slot[S_ID], in_instr, st || mem_wait, 1'b0,
                        pc_redir || misp_mem);
    model_slot[S_ID]  = nxt_id;
    model_slot[S_EX]  = nxt_ex;
    model_slot[S_MEM] = nxt_mem;
    model_slot[S_WB]  = nxt_wb;
    consumed     = !st && !mem_wait;
    wait_at_edge = mem_wait;
  endtask

  task automatic note_retire(input logic [7:0] tag);
    logic [7:0] step;
    step = tag - last_tag;
    // Tags only grow between retirements, allowing for the 8-bit wrap
    if ((retired > 0) && ((step == 8'd0) || (step >= 8'd128))) begin
      $display("Tag 0x%0h retired out of order, the previous tag was 0x%0h", tag, last_tag);
      errors = errors + 1;
    end
    if ((cyc - present_cyc[tag]) < 4) begin
      $display("Tag 0x%0h retired only %0d cycles after it was offered", tag,
               cyc - present_cyc[tag]);
      errors = errors + 1;
    end
    last_tag = tag;
    retired = retired + 1;
  endtask

  task automatic check_outputs();
    logic        exp_stall;
    logic        exp_redirect;
    fwd_sel_e    exp_rs1;
    fwd_sel_e    exp_rs2;
    instr_desc_t exp_wb;
    exp_stall = expect_stall(model_slot[S_ID], model_slot[S_EX], model_slot[S_MEM],
                             model_slot[S_WB]);
    exp_redirect = control_change(model_slot[S_EX], model_slot[S_MEM]);
    exp_rs1 = expect_fwd(model_slot[S_ID].rs1, model_slot[S_ID].rs1_used,
                         model_slot[S_MEM], model_slot[S_WB]);
    exp_rs2 = expect_fwd(model_slot[S_ID].rs2, model_slot[S_ID].rs2_used,
                         model_slot[S_MEM], model_slot[S_WB]);
    exp_wb = model_slot[S_WB];
    checks = checks + 1;
    if (stall !== exp_stall) begin
      $display("Fail stall: got 0x%0h, expected 0x%0h", stall, exp_stall);
      errors = errors + 1;
    end
    if (redirect !== exp_redirect) begin
      $display("Fail redirect: got 0x%0h, expected 0x%0h", redirect, exp_redirect);
      errors = errors + 1;
    end
    if (fwd_rs1 !== exp_rs1) begin
      $display("Fail fwd_rs1: got 0x%0h, expected 0x%0h", fwd_rs1, exp_rs1);
      errors = errors + 1;
    end
    if (fwd_rs2 !== exp_rs2) begin
      $display("Fail fwd_rs2: got 0x%0h, expected 0x%0h", fwd_rs2, exp_rs2);
      errors = errors + 1;
    end
    // The fields of a bubble in WB carry no meaning, so they are compared only when valid
    if (wb_instr.valid !== exp_wb.valid) begin
      $display("Fail wb_instr.valid: got 0x%0h, expected 0x%0h", wb_instr.valid, exp_wb.valid);
      errors = errors + 1;
    end else if (exp_wb.valid && (wb_instr !== exp_wb)) begin
      $display("Fail wb_instr: got 0x%0h, expected 0x%0h", wb_instr, exp_wb);
      errors = errors + 1;
    end
    if (wait_at_edge && (wb_instr.valid !== 1'b0)) begin
      $display("WB holds a valid instruction right after a memory wait");
      errors = errors + 1;
    end
    if (wb_instr.valid === 1'b1) begin
      note_retire(wb_instr.tag);
    end
  endtask

  task automatic check_reset_state();
    if (stall !== 1'b0) begin
      $display("Stall is not low after reset");
      errors = errors + 1;
    end
    if (redirect !== 1'b0) begin
      $display("Redirect is not low after reset");
      errors = errors + 1;
    end
    if (wb_instr.valid !== 1'b0) begin
      $display("WB holds a valid instruction after reset");
      errors = errors + 1;
    end
  endtask

  function automatic logic pipe_empty();
    return !model_slot[S_ID].valid && !model_slot[S_EX].valid &&
           !model_slot[S_MEM].valid && !model_slot[S_WB].valid && !in_instr.valid;
  endfunction

  initial begin
    clk           = 1'b0;
    reset         = 1'b1;
    mem_wait      = 1'b0;
    in_instr      = '0;
    rng           = SEED;
    next_tag      = 8'd0;
    last_tag      = 8'd0;
    consumed      = 1'b1;
    wait_at_edge  = 1'b0;
    draining      = 1'b0;
    cyc           = 0;
    timeout_count = 0;
    checks        = 0;
    errors        = 0;
    retired       = 0;
    for (int i = 0; i < 4; i++) begin
      model_slot[i] = '0;
    end

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    check_reset_state();

    // Random stimulus runs first, and empty offers follow until the pipeline has drained
    while ((cyc < STIM_CYCLES) || !pipe_empty()) begin
      draining = (cyc >= STIM_CYCLES);
      drive_inputs();
      #1;
      check_outputs();
      @(posedge clk);
      advance_model();
      cyc = cyc + 1;
      @(negedge clk);
    end

    $display("Checks %0d, errors %0d, retired %0d", checks, errors, retired);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- sources.f
source/rv_pipe_pkg.sv
source/rv_stage_reg.sv
source/rv_id_stage.sv
source/rv_hazard_ctrl.sv
source/rv_fwd_id.sv
source/rv_pipe_top.sv
test/rv_pipe_tb.sv

//--- Bender.yml
package:
  name: rv_pipe_ctrl

sources:
  - files:
      - source/rv_pipe_pkg.sv
      - source/rv_stage_reg.sv
      - source/rv_id_stage.sv
      - source/rv_hazard_ctrl.sv
      - source/rv_fwd_id.sv
      - source/rv_pipe_top.sv
  - target: test
    files:
      - test/rv_pipe_tb.sv
